// File: hdl/frame_counter.sv
module frame_counter (
    input  logic clk,
    input  logic reset_b,
    input  logic hold_load,
    input  logic beat_accept,
    output logic beat_last,
    output logic send_frame
);

    // Position of the next beat to be loaded
    logic [$clog2(stream_tx_pkg::frame_beats)-1:0] pos;
    // Last flag of the beat currently presented
    logic                                          pres_last;
    logic                                          in_frame;

    assign beat_last = (int'(pos) == stream_tx_pkg::frame_beats - 1);

    ////////////////////////////////////////
    // Load position
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            pos       <= '0;
            pres_last <= 1'b0;
        end else if (hold_load) begin
            pos       <= beat_last ? '0 : pos + 1'b1;
            pres_last <= beat_last;
        end
    end

    ////////////////////////////////////////
    // Frame activity
    ////////////////////////////////////////

    // Set on loading position 0, which wins over the clear when the
    // next frame's first beat is loaded as the last one transfers
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            in_frame <= 1'b0;
        end else if (hold_load && pos == '0) begin
            in_frame <= 1'b1;
        end else if (beat_accept && pres_last) begin
            in_frame <= 1'b0;
        end
    end

    assign send_frame = in_frame;

endmodule

// File: hdl/sample_capture.sv
module sample_capture (
    input  logic                   clk,
    input  logic                   reset_b,
    input  logic                   src_req,
    input  stream_tx_pkg::sample_t src_data,
    input  logic                   cap_take,
    output logic                   src_ack,
    output stream_tx_pkg::sample_t cap_sample,
    output logic                   cap_full
);

    stream_tx_pkg::sample_t buffer;
    logic                   full;
    logic                   ack;
    logic                   capture;

    // New request seen, not yet acknowledged, and room in the buffer
    assign capture = src_req && !ack && !full;

    ////////////////////////////////////////
    // Four-phase ack
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            ack <= 1'b0;
        end else if (capture) begin
            ack <= 1'b1;
        end else if (!src_req) begin
            // Return to zero once the producer drops req
            ack <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // One-entry buffer
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            full <= 1'b0;
        end else if (capture) begin
            full <= 1'b1;
        end else if (cap_take) begin
            full <= 1'b0;
        end
    end

    // Payload only, the full flag says when it is valid
    always_ff @(posedge clk) begin
        if (capture) begin
            buffer <= src_data;
        end
    end

    assign src_ack    = ack;
    assign cap_full   = full;
    assign cap_sample = buffer;

endmodule

// File: hdl/stream_data_hold.sv
module stream_data_hold (
    input  logic                   clk,
    input  logic                   reset_b,
    input  stream_tx_pkg::sample_t cap_sample,
    input  logic                   beat_last,
    input  logic                   hold_load,
    output stream_tx_pkg::beat_t   out_beat
);

    stream_tx_pkg::beat_t beat_q;
    stream_tx_pkg::beat_t beat_new;

    ////////////////////////////////////////
    // New beat assembly
    ////////////////////////////////////////

    // Sample from the buffer plus the frame position flag
    always_comb begin
        beat_new.data = cap_sample.data;
        beat_new.last = beat_last;
    end

    ////////////////////////////////////////
    // New/old select register
    ////////////////////////////////////////

    // hold_load high takes the new beat, low keeps the old one so an
    // unaccepted beat stays put under back-pressure
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            beat_q <= '0;
        end else if (hold_load) begin
            beat_q <= beat_new;
        end else begin
            beat_q <= beat_q;
        end
    end

    assign out_beat = beat_q;

endmodule

// File: hdl/stream_tx_ctrl.sv
module stream_tx_ctrl (
    input  logic clk,
    input  logic reset_b,
    input  logic cap_full,
    input  logic t_ready,
    output logic cap_take,
    output logic hold_load,
    output logic beat_accept,
    output logic t_valid
);

    stream_tx_pkg::ctrl_state_t state;
    stream_tx_pkg::ctrl_state_t state_next;
    logic                       presented;
    logic                       transfer;
    logic                       load;

    ////////////////////////////////////////
    // State register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= stream_tx_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////
    // Load and transfer decode
    ////////////////////////////////////////

    // A beat sits on the port in send and hold
    assign presented = (state == stream_tx_pkg::send) || (state == stream_tx_pkg::hold);
    assign transfer  = presented && t_ready;

    // Refill when the port is empty or being emptied this cycle
    assign load = cap_full && (!presented || transfer);

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        state_next = state;
        unique case (state)
            stream_tx_pkg::idle: begin
                if (load) begin
                    state_next = stream_tx_pkg::send;
                end
            end
            stream_tx_pkg::send,
            stream_tx_pkg::hold: begin
                if (!t_ready) begin
                    // Stalled, keep the old beat
                    state_next = stream_tx_pkg::hold;
                end else if (load) begin
                    state_next = stream_tx_pkg::send;
                end else begin
                    // Accepted and nothing to replace it
                    state_next = stream_tx_pkg::idle;
                end
            end
            default: begin
                state_next = stream_tx_pkg::idle;
            end
        endcase
    end

    assign t_valid     = presented;
    assign hold_load   = load;
    assign cap_take    = load;
    assign beat_accept = transfer;

endmodule

// File: hdl/stream_tx_pkg.sv
package stream_tx_pkg;

    ////////////////////////////////////////
    // Stream geometry
    ////////////////////////////////////////

    // Width of one upstream sample
    localparam int data_width = 10;

    // Beats in every frame, t_last on the final one
    localparam int frame_beats = 8;

    ////////////////////////////////////////
    // Payload types
    ////////////////////////////////////////

    // One sample as received from the producer
    typedef struct packed {
        logic [data_width-1:0] data;
    } sample_t;

    // One beat as presented on the output port
    typedef struct packed {
        logic [data_width-1:0] data;
        logic                  last;
    } beat_t;

    ////////////////////////////////////////
    // Controller
    ////////////////////////////////////////

    // idle   no beat presented
    // send   beat presented, new or after t_ready high
    // hold   beat presented and stalled by t_ready
    typedef enum logic [1:0] {
        idle = 2'b00,
        send = 2'b01,
        hold = 2'b10
    } ctrl_state_t;

endpackage

// File: hdl/stream_tx_top.sv
module stream_tx_top (
    input  logic                                  clk,
    input  logic                                  reset_b,
    input  logic                                  src_req,
    input  stream_tx_pkg::sample_t                src_data,
    input  logic                                  t_ready,
    output logic                                  src_ack,
    output logic                                  t_valid,
    output logic [stream_tx_pkg::data_width-1:0]  t_data,
    output logic                                  t_last,
    output logic                                  send_frame
);

    stream_tx_pkg::sample_t cap_sample;
    stream_tx_pkg::beat_t   out_beat;
    logic                   cap_full;
    logic                   cap_take;
    logic                   hold_load;
    logic                   beat_accept;
    logic                   beat_last;

    ////////////////////////////////////////
    // Upstream capture and output beat
    ////////////////////////////////////////

    sample_capture i_capture (
        .clk        (clk),
        .reset_b    (reset_b),
        .src_req    (src_req),
        .src_data   (src_data),
        .cap_take   (cap_take),
        .src_ack    (src_ack),
        .cap_sample (cap_sample),
        .cap_full   (cap_full)
    );

    stream_data_hold i_hold (
        .clk        (clk),
        .reset_b    (reset_b),
        .cap_sample (cap_sample),
        .beat_last  (beat_last),
        .hold_load  (hold_load),
        .out_beat   (out_beat)
    );

    ////////////////////////////////////////
    // Framing and control
    ////////////////////////////////////////

    frame_counter i_frame (
        .clk         (clk),
        .reset_b     (reset_b),
        .hold_load   (hold_load),
        .beat_accept (beat_accept),
        .beat_last   (beat_last),
        .send_frame  (send_frame)
    );

    stream_tx_ctrl i_ctrl (
        .clk         (clk),
        .reset_b     (reset_b),
        .cap_full    (cap_full),
        .t_ready     (t_ready),
        .cap_take    (cap_take),
        .hold_load   (hold_load),
        .beat_accept (beat_accept),
        .t_valid     (t_valid)
    );

    assign t_data = out_beat.data;
    assign t_last = out_beat.last;

endmodule

// File: stream_tx.f
hdl/stream_tx_pkg.sv
hdl/sample_capture.sv
hdl/stream_data_hold.sv
hdl/frame_counter.sv
hdl/stream_tx_ctrl.sv
hdl/stream_tx_top.sv
test/tb_clock.sv
test/stream_tx_assertions.sv
test/stream_tx_tb.sv

// File: test/stream_tx_assertions.sv
module stream_tx_assertions (
    input logic                                 clk,
    input logic                                 reset_b,
    input logic                                 src_req,
    input logic                                 src_ack,
    input logic                                 t_valid,
    input logic                                 t_ready,
    input logic [stream_tx_pkg::data_width-1:0] t_data,
    input logic                                 t_last
);

    timeunit 1ns;
    timeprecision 1ps;

    // Read by the testbench top for the closing count
    int unsigned fail_count = 0;

    ////////////////////////////////////////
    // Upstream four-phase
    ////////////////////////////////////////

    ack_needs_req: assert property (@(posedge clk) disable iff (!reset_b)
        !src_req && !src_ack |=> !src_ack)
    else begin
        fail_count++;
        $error("src_ack rose while src_req was low");
    end

    ////////////////////////////////////////
    // Downstream valid/ready
    ////////////////////////////////////////

    // Stalled beat must not change
    beat_stable: assert property (@(posedge clk) disable iff (!reset_b)
        t_valid && !t_ready |=> $stable(t_data) && $stable(t_last))
    else begin
        fail_count++;
        $error("t_data or t_last changed while the beat was stalled");
    end

    valid_held: assert property (@(posedge clk) disable iff (!reset_b)
        t_valid && !t_ready |=> t_valid)
    else begin
        fail_count++;
        $error("t_valid dropped without a transfer");
    end

endmodule

// File: test/stream_tx_stimulus.txt
# Columns: sample value (hex, 10 bits), gap in cycles before the next request
# Closing line: frames followed by the expected frame count
0a5 2
3ff 0
000 1
155 3
2aa 0
07c 4
1e3 1
321 0
0f0 5
10f 0
2c4 2
39b 1
05e 0
1a7 3
260 0
0d9 1
3c2 4
14b 0
276 2
08e 0
1f1 1
333 0
0c7 5
2e8 0
11d 2
3a0 1
062 0
1b9 3
24f 0
0a1 2
38c 1
17e 0
2d5 0
046 0
3e7 0
129 0
0bb 0
292 0
1c0 0
35f 0
frames 5

// File: test/stream_tx_tb.sv
module stream_tx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                                 clk;
    logic                                 reset_b;
    logic                                 src_req;
    stream_tx_pkg::sample_t               src_data;
    logic                                 t_ready;
    logic                                 src_ack;
    logic                                 t_valid;
    logic [stream_tx_pkg::data_width-1:0] t_data;
    logic                                 t_last;
    logic                                 send_frame;

    logic [stream_tx_pkg::data_width-1:0] samples[$];
    logic [stream_tx_pkg::data_width-1:0] expected[$];
    int                                   gaps[$];
    int                                   expected_frames = 0;
    int                                   max_gap = 0;
    int                                   timeout_cycles = 0;
    bit                                   loaded = 1'b0;
    bit                                   running = 1'b0;
    logic [15:0]                          rand_state = 16'd60209;
    logic                                 rand_a;
    logic                                 rand_b;
    int                                   transfers = 0;
    int                                   frames = 0;
    int                                   acks = 0;
    int                                   overlaps = 0;
    int                                   cycle = 0;
    int                                   last_cycle = 0;
    int                                   value_errors = 0;
    int                                   flow_errors = 0;
    bit                                   after_last = 1'b0;
    bit                                   next_first = 1'b0;
    logic                                 prev_ack = 1'b0;

    tb_clock i_clock (
        .clk (clk)
    );

    stream_tx_top i_dut (
        .clk        (clk),
        .reset_b    (reset_b),
        .src_req    (src_req),
        .src_data   (src_data),
        .t_ready    (t_ready),
        .src_ack    (src_ack),
        .t_valid    (t_valid),
        .t_data     (t_data),
        .t_last     (t_last),
        .send_frame (send_frame)
    );

    bind stream_tx_top stream_tx_assertions i_assertions (
        .clk     (clk),
        .reset_b (reset_b),
        .src_req (src_req),
        .src_ack (src_ack),
        .t_valid (t_valid),
        .t_ready (t_ready),
        .t_data  (t_data),
        .t_last  (t_last)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (exp_v === act_v) else begin
            $display("FAIL %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
            value_errors++;
        end
    endtask

    task automatic check_flow(input bit ok, input string what);
        assert (ok) else begin
            $display("%0t %s", $time, what);
            flow_errors++;
        end
    endtask

    task automatic read_stimulus();
        int    fd;
        int    value;
        int    gap;
        string line;
        fd = $fopen("test/stream_tx_stimulus.txt", "r");
        check_flow(fd != 0, "Could not open test/stream_tx_stimulus.txt");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                if ($sscanf(line, "frames %d", value) == 1) begin
                    expected_frames = value;
                end else if ($sscanf(line, "%h %d", value, gap) == 2) begin
                    samples.push_back(value);
                    gaps.push_back(gap);
                    if (gap > max_gap) begin
                        max_gap = gap;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Four-phase producer, ack sampled on the falling edge
    task automatic run_producer();
        for (int i = 0; i < samples.size(); i++) begin
            @(posedge clk);
            src_data.data <= samples[i];
            src_req       <= 1'b1;
            expected.push_back(samples[i]);
            do @(negedge clk); while (src_ack !== 1'b1);
            @(posedge clk);
            src_req <= 1'b0;
            do @(negedge clk); while (src_ack !== 1'b0);
            repeat (gaps[i]) @(posedge clk);
        end
    endtask

    ////////////////////////////////////////
    // Back-pressure
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (!running) begin
            t_ready <= 1'b0;
        end else if (transfers >= samples.size() - stream_tx_pkg::frame_beats) begin
            // Final frame with the port always ready
            t_ready <= 1'b1;
        end else begin
            rand_state = lfsr_next(rand_state);
            rand_a     = rand_state[0];
            rand_state = lfsr_next(rand_state);
            rand_b     = rand_state[0];
            t_ready <= rand_a && rand_b;
        end
    end

    ////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (running) begin
            cycle++;
            // Frame ends unless the next first beat is already up
            if (after_last) begin
                check_value("send_frame", next_first, send_frame);
            end
            after_last = 1'b0;
            if (src_ack && !prev_ack) begin
                acks++;
                check_flow(src_req, "src_ack rose without a pending src_req");
                if (t_valid) begin
                    overlaps++;
                end
            end
            if (!src_ack && prev_ack) begin
                check_flow(!src_req, "src_ack fell while src_req was still high");
            end
            prev_ack = src_ack;
            if (t_valid && t_ready) begin
                transfers++;
                check_value("send_frame", 1'b1, send_frame);
                check_value("t_last", (transfers % stream_tx_pkg::frame_beats) == 0, t_last);
                if (expected.size() == 0) begin
                    check_flow(1'b0, "Beat transferred with no sample outstanding");
                end else begin
                    check_value("t_data", expected.pop_front(), t_data);
                end
                if (t_last) begin
                    frames++;
                    after_last = 1'b1;
                    // A captured sample still waiting becomes the next first beat
                    next_first = acks > transfers;
                end
                // Final frame keeps up with one producer handshake
                if (transfers > samples.size() - stream_tx_pkg::frame_beats + 1) begin
                    check_flow(cycle - last_cycle <= 4, "Final frame beat was delayed");
                end
                last_cycle = cycle;
            end
        end
    end

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        reset_b  = 1'b0;
        src_req  = 1'b0;
        src_data = '0;
        t_ready  = 1'b0;
        read_stimulus();
        timeout_cycles = 16 + samples.size() * (max_gap + 20);
        loaded = 1'b1;
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_value("src_ack", 1'b0, src_ack);
        check_value("t_valid", 1'b0, t_valid);
        check_value("t_last", 1'b0, t_last);
        check_value("send_frame", 1'b0, send_frame);
        @(posedge clk);
        reset_b <= 1'b1;
        running <= 1'b1;
        run_producer();
        while (transfers < samples.size()) @(negedge clk);
        // Idle cycles to catch any extra beat
        repeat (10) @(negedge clk);
        check_value("transfers", samples.size(), transfers);
        check_value("frames", expected_frames, frames);
        check_value("src_ack rises", samples.size(), acks);
        check_flow(overlaps > 0, "No sample was captured while a beat was presented");
        $display("Errors: value %0d, flow %0d, assertion %0d",
                 value_errors, flow_errors, i_dut.i_assertions.fail_count);
        if (value_errors + flow_errors + i_dut.i_assertions.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (timeout_cycles) @(posedge clk);
        $display("Run timed out after %0d cycles before all beats were sent",
                 timeout_cycles);
        $display("sim failed");
        $finish;
    end

endmodule

// File: test/tb_clock.sv
module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period, starts low
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

endmodule
